// ==== rtl/cam_display_pkg.sv ====
// camera display shared definitions
`default_nettype none

package cam_display_pkg;

    // 640x480 at 60 Hz raster, 25 MHz pixel clock
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 800

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 525 lines

    // frame buffer, shown at double scale
    localparam int FB_WIDTH    = 320;
    localparam int FB_HEIGHT   = 240;
    localparam int FB_DEPTH    = FB_WIDTH * FB_HEIGHT;  // 76800 words
    localparam int BANK0_DEPTH = 32768;                 // rest lives in bank 1

    // read path latencies
    localparam int MEM_RD_LAT = 2;  // address reg + output reg
    localparam int PIX_LAT    = 1;
    localparam int SYNC_DELAY = MEM_RD_LAT + PIX_LAT;

    typedef logic [16:0] fb_addr_t;
    typedef logic [15:0] bank_addr_t;
    typedef logic [15:0] rgb565_t;  // r[15:11] g[10:5] b[4:0]
    typedef logic [7:0]  chan8_t;

    typedef struct packed {
        chan8_t r;
        chan8_t g;
        chan8_t b;
    } rgb888_t;

    // raster counters
    typedef logic [9:0] h_count_t;
    typedef logic [9:0] v_count_t;

endpackage

`default_nettype wire

// ==== rtl/vga_timing.sv ====
// VGA raster generator
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  logic                        clk_25_vga,
    input  logic                        rst_n,
    output cam_display_pkg::fb_addr_t   rd_addr,
    output logic                        rd_active,
    output logic                        vga_hsync,
    output logic                        vga_vsync,
    output logic                        vga_blank_n
);

    cam_display_pkg::h_count_t h_count;
    cam_display_pkg::v_count_t v_count;

    cam_display_pkg::fb_addr_t row_base;   // first word of the buffer row
    logic hsync_raw;
    logic vsync_raw;
    logic active;

    logic [cam_display_pkg::SYNC_DELAY-1:0] hsync_pipe;
    logic [cam_display_pkg::SYNC_DELAY-1:0] vsync_pipe;
    logic [cam_display_pkg::SYNC_DELAY-1:0] blank_pipe;

    // free-running pixel and line counters
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == cam_display_pkg::h_count_t'(cam_display_pkg::H_TOTAL - 1)) begin
            h_count <= '0;
            if (v_count == cam_display_pkg::v_count_t'(cam_display_pkg::V_TOTAL - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // sync windows, both active low
    assign hsync_raw = !((h_count >= cam_display_pkg::H_ACTIVE + cam_display_pkg::H_FRONT) &&
                         (h_count <  cam_display_pkg::H_ACTIVE + cam_display_pkg::H_FRONT +
                                     cam_display_pkg::H_SYNC));
    // v only moves at line start, so vsync edges land on line starts
    assign vsync_raw = !((v_count >= cam_display_pkg::V_ACTIVE + cam_display_pkg::V_FRONT) &&
                         (v_count <  cam_display_pkg::V_ACTIVE + cam_display_pkg::V_FRONT +
                                     cam_display_pkg::V_SYNC));

    assign active = (h_count < cam_display_pkg::H_ACTIVE) && (v_count < cam_display_pkg::V_ACTIVE);

    // each buffer pixel covers 2x2 screen pixels
    assign row_base  = cam_display_pkg::fb_addr_t'(v_count[9:1]) *
                       cam_display_pkg::fb_addr_t'(cam_display_pkg::FB_WIDTH);
    assign rd_addr   = row_base + cam_display_pkg::fb_addr_t'(h_count[9:1]);
    assign rd_active = active;

    // line sync and blank up with the colour pipeline
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            hsync_pipe <= '1;   // idle high
            vsync_pipe <= '1;
            blank_pipe <= '0;   // blanked
        end else begin
            hsync_pipe <= {hsync_pipe[cam_display_pkg::SYNC_DELAY-2:0], hsync_raw};
            vsync_pipe <= {vsync_pipe[cam_display_pkg::SYNC_DELAY-2:0], vsync_raw};
            blank_pipe <= {blank_pipe[cam_display_pkg::SYNC_DELAY-2:0], active};
        end
    end

    assign vga_hsync   = hsync_pipe[cam_display_pkg::SYNC_DELAY-1];
    assign vga_vsync   = vsync_pipe[cam_display_pkg::SYNC_DELAY-1];
    assign vga_blank_n = blank_pipe[cam_display_pkg::SYNC_DELAY-1];

endmodule

`default_nettype wire

// ==== rtl/frame_buffer_bank.sv ====
// frame buffer memory bank
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_bank #(
    parameter int DEPTH = cam_display_pkg::BANK0_DEPTH
) (
    input  logic                            clk_25_vga,
    input  logic                            we,
    input  cam_display_pkg::bank_addr_t     waddr,
    input  cam_display_pkg::rgb565_t        wdata,
    input  cam_display_pkg::bank_addr_t     raddr,
    output cam_display_pkg::rgb565_t        rdata
);

    localparam int AW = $clog2(DEPTH);  // index bits actually needed

    cam_display_pkg::rgb565_t mem [0:DEPTH-1];
    logic [AW-1:0] raddr_q;

    always_ff @(posedge clk_25_vga) begin
        if (we) begin
            mem[waddr[AW-1:0]] <= wdata;
        end
    end

    // registered address then registered data, MEM_RD_LAT clocks
    always_ff @(posedge clk_25_vga) begin
        raddr_q <= raddr[AW-1:0];
        rdata   <= mem[raddr_q];
    end

endmodule

`default_nettype wire

// ==== rtl/frame_buffer.sv ====
// two-bank frame buffer
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
    input  logic                        clk_25_vga,
    input  logic                        rst_n,
    input  logic                        wr_en,
    input  cam_display_pkg::fb_addr_t   wr_addr,
    input  cam_display_pkg::rgb565_t    wr_data,
    input  cam_display_pkg::fb_addr_t   rd_addr,
    input  logic                        rd_active,
    output cam_display_pkg::rgb565_t    rd_data,
    output logic                        data_active
);

    logic wr_in_range;
    logic wr_hi;            // write targets bank 1
    logic rd_hi;            // read targets bank 1
    logic we0;
    logic we1;

    cam_display_pkg::bank_addr_t waddr0, waddr1;
    cam_display_pkg::bank_addr_t raddr0, raddr1;
    cam_display_pkg::rgb565_t    rdata0, rdata1;

    logic [cam_display_pkg::MEM_RD_LAT-1:0] sel_pipe;
    logic [cam_display_pkg::MEM_RD_LAT-1:0] act_pipe;

    assign wr_in_range = wr_addr < cam_display_pkg::FB_DEPTH;   // anything past the frame is dropped
    assign wr_hi       = wr_addr >= cam_display_pkg::BANK0_DEPTH;
    assign we0         = wr_en && wr_in_range && !wr_hi;
    assign we1         = wr_en && wr_in_range && wr_hi;

    assign waddr0 = cam_display_pkg::bank_addr_t'(wr_addr);
    assign waddr1 = cam_display_pkg::bank_addr_t'(wr_addr - cam_display_pkg::BANK0_DEPTH);

    assign rd_hi  = rd_addr >= cam_display_pkg::BANK0_DEPTH;
    assign raddr0 = cam_display_pkg::bank_addr_t'(rd_addr);
    assign raddr1 = cam_display_pkg::bank_addr_t'(rd_addr - cam_display_pkg::BANK0_DEPTH);

    frame_buffer_bank #(
        .DEPTH (cam_display_pkg::BANK0_DEPTH)
    ) bank0_inst (
        .clk_25_vga (clk_25_vga),
        .we         (we0),
        .waddr      (waddr0),
        .wdata      (wr_data),
        .raddr      (raddr0),
        .rdata      (rdata0)
    );

    frame_buffer_bank #(
        .DEPTH (cam_display_pkg::FB_DEPTH - cam_display_pkg::BANK0_DEPTH)
    ) bank1_inst (
        .clk_25_vga (clk_25_vga),
        .we         (we1),
        .waddr      (waddr1),
        .wdata      (wr_data),
        .raddr      (raddr1),
        .rdata      (rdata1)
    );

    // bank select and active follow the data through the memory latency
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            sel_pipe <= '0;
            act_pipe <= '0;
        end else begin
            sel_pipe <= {sel_pipe[cam_display_pkg::MEM_RD_LAT-2:0], rd_hi};
            act_pipe <= {act_pipe[cam_display_pkg::MEM_RD_LAT-2:0], rd_active};
        end
    end

    assign rd_data     = sel_pipe[cam_display_pkg::MEM_RD_LAT-1] ? rdata1 : rdata0;
    assign data_active = act_pipe[cam_display_pkg::MEM_RD_LAT-1];

endmodule

`default_nettype wire

// ==== rtl/pixel_convert.sv ====
// RGB565 to RGB888 pixel stage with grayscale mode
`timescale 1ns/1ps
`default_nettype none

module pixel_convert (
    input  logic                        clk_25_vga,
    input  logic                        rst_n,
    input  cam_display_pkg::rgb565_t    rd_data,
    input  logic                        data_active,
    input  logic                        sw_grayscale,
    output cam_display_pkg::rgb888_t    pixel
);

    cam_display_pkg::chan8_t  r8;
    cam_display_pkg::chan8_t  g8;
    cam_display_pkg::chan8_t  b8;
    cam_display_pkg::chan8_t  gray;
    logic [15:0]              gray_sum;    // weights add to 252, no overflow
    cam_display_pkg::rgb888_t pixel_next;

    // pad low bits with ones
    assign r8 = {rd_data[15:11], 3'b111};
    assign g8 = {rd_data[10:5],  2'b11};
    assign b8 = {rd_data[4:0],   3'b111};

    // luma approx (76 r + 150 g + 26 b) / 256
    assign gray_sum = 16'd76 * r8 + 16'd150 * g8 + 16'd26 * b8;
    assign gray     = gray_sum[15:8];

    always_comb begin
        if (!data_active) begin
            pixel_next = '0;        // black outside the picture
        end else if (sw_grayscale) begin
            pixel_next.r = gray;
            pixel_next.g = gray;
            pixel_next.b = gray;
        end else begin
            pixel_next.r = r8;
            pixel_next.g = g8;
            pixel_next.b = b8;
        end
    end

    // single output register, PIX_LAT
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            pixel <= '0;
        end else begin
            pixel <= pixel_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cam_display_top.sv ====
// camera display top level
`timescale 1ns/1ps
`default_nettype none

module cam_display_top (
    input  logic                        clk_25_vga,
    input  logic                        rst_n,
    input  logic                        wr_en,
    input  cam_display_pkg::fb_addr_t   wr_addr,
    input  cam_display_pkg::rgb565_t    wr_data,
    input  logic                        sw_grayscale,
    output logic                        vga_hsync,
    output logic                        vga_vsync,
    output logic                        vga_blank_n,
    output cam_display_pkg::chan8_t     vga_r,
    output cam_display_pkg::chan8_t     vga_g,
    output cam_display_pkg::chan8_t     vga_b
);

    cam_display_pkg::fb_addr_t  rd_addr;
    logic                       rd_active;
    cam_display_pkg::rgb565_t   rd_data;
    logic                       data_active;
    cam_display_pkg::rgb888_t   pixel;

    vga_timing vga_timing_inst (
        .clk_25_vga  (clk_25_vga),
        .rst_n       (rst_n),
        .rd_addr     (rd_addr),
        .rd_active   (rd_active),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_blank_n (vga_blank_n)
    );

    frame_buffer frame_buffer_inst (
        .clk_25_vga  (clk_25_vga),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_addr     (rd_addr),
        .rd_active   (rd_active),
        .rd_data     (rd_data),
        .data_active (data_active)
    );

    pixel_convert pixel_convert_inst (
        .clk_25_vga   (clk_25_vga),
        .rst_n        (rst_n),
        .rd_data      (rd_data),
        .data_active  (data_active),
        .sw_grayscale (sw_grayscale),
        .pixel        (pixel)
    );

    assign vga_r = pixel.r;
    assign vga_g = pixel.g;
    assign vga_b = pixel.b;

endmodule

`default_nettype wire

// ==== verification/tb_cam_display.sv ====
// camera display testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cam_display;

    localparam int FRAME_CYCLES   = cam_display_pkg::H_TOTAL * cam_display_pkg::V_TOTAL;
    // load + first vsync wait + three frames is about 1.76M cycles
    localparam int TIMEOUT_CYCLES = 2_000_000;
    // addresses past the frame that mostly alias onto bank 1 words if truncated
    localparam cam_display_pkg::fb_addr_t BAD_ADDR [4] =
        '{17'd76800, 17'd98304, 17'd109568, 17'h1ffff};

    logic                      clk_25_vga = 1'b0;
    logic                      rst_n;
    logic                      wr_en;
    cam_display_pkg::fb_addr_t wr_addr;
    cam_display_pkg::rgb565_t  wr_data;
    logic                      sw_grayscale;
    logic                      vga_hsync;
    logic                      vga_vsync;
    logic                      vga_blank_n;
    cam_display_pkg::chan8_t   vga_r;
    cam_display_pkg::chan8_t   vga_g;
    cam_display_pkg::chan8_t   vga_b;

    cam_display_pkg::rgb565_t ref_frame [0:cam_display_pkg::FB_DEPTH-1];
    int seed;
    int cycle_count = 0;
    int waited;

    // frame monitor state
    int   cyc_in_frame;
    int   pix_k;
    int   hs_pulses;
    int   hs_width;
    int   hs_prev_fall;
    int   vs_low;
    int   blank_run;
    int   blank_lines;
    logic hs_prev;
    logic blank_prev;
    logic gray_mode;
    logic vs_prev = 1'b0;

    always #4 clk_25_vga = ~clk_25_vga;   // 8 ns

    cam_display_top cam_display_top_inst (
        .clk_25_vga   (clk_25_vga),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .sw_grayscale (sw_grayscale),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_blank_n  (vga_blank_n),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b)
    );

    always @(posedge clk_25_vga) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run hung: no end of test after %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_pixel(input cam_display_pkg::rgb888_t got,
                               input cam_display_pkg::rgb888_t exp,
                               input string what, input int pos);
        if (got !== exp) begin
            $display("ERR %0t: %s at frame cycle %0d got %06h expected %06h",
                     $time, what, pos, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "pixel mismatch");
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    // screen pixel (h, v) from the reference frame at double scale
    function automatic cam_display_pkg::rgb888_t expected_pixel(input int h, input int v,
                                                               input logic gray);
        cam_display_pkg::rgb888_t p;
        cam_display_pkg::rgb565_t w;
        int sum;
        w   = ref_frame[(v / 2) * cam_display_pkg::FB_WIDTH + h / 2];
        p.r = {w[15:11], 3'b111};
        p.g = {w[10:5], 2'b11};
        p.b = {w[4:0], 3'b111};
        sum = 76 * p.r + 150 * p.g + 26 * p.b;
        if (gray) begin
            p.r = cam_display_pkg::chan8_t'(sum >> 8);
            p.g = p.r;
            p.b = p.r;
        end
        return p;
    endfunction

    task automatic check_idle_outputs(input string when);
        check_count(int'(vga_hsync), 1, {"hsync ", when});
        check_count(int'(vga_vsync), 1, {"vsync ", when});
        check_count(int'(vga_blank_n), 0, {"blank_n ", when});
        check_pixel({vga_r, vga_g, vga_b}, '0, {"colour ", when}, 0);
    endtask

    // one negedge sample of the VGA outputs
    task automatic sample_outputs();
        cam_display_pkg::rgb888_t got;
        int h;
        int v;
        got = {vga_r, vga_g, vga_b};
        if (!vga_hsync && hs_prev) begin
            if (hs_prev_fall >= 0) begin
                check_count(cyc_in_frame - hs_prev_fall, cam_display_pkg::H_TOTAL, "hsync period");
            end
            hs_prev_fall = cyc_in_frame;
            hs_pulses++;
        end
        if (vga_hsync && !hs_prev) begin
            check_count(hs_width, cam_display_pkg::H_SYNC, "hsync width");
        end
        hs_width = vga_hsync ? 0 : hs_width + 1;
        if (!vga_vsync) begin
            vs_low++;
        end
        if (vga_blank_n) begin
            h = pix_k % cam_display_pkg::H_ACTIVE;
            v = pix_k / cam_display_pkg::H_ACTIVE;
            check_pixel(got, expected_pixel(h, v, gray_mode), "active pixel", cyc_in_frame);
            pix_k++;
            blank_run++;
        end else begin
            check_pixel(got, '0, "blanking", cyc_in_frame);
            if (blank_prev) begin
                check_count(blank_run, cam_display_pkg::H_ACTIVE, "active line length");
                blank_lines++;
            end
            blank_run = 0;
        end
        hs_prev      = vga_hsync;
        vs_prev      = vga_vsync;
        blank_prev   = vga_blank_n;
        cyc_in_frame++;
    endtask

    task automatic wait_vsync_fall(output int cycles);
        logic fell;
        fell   = 1'b0;
        cycles = 0;
        while (!fell) begin
            @(negedge clk_25_vga);
            fell = vs_prev && !vga_vsync;
            vs_prev = vga_vsync;
            cycles++;
        end
    endtask

    // monitor one frame from the vsync fall just sampled
    task automatic run_frame(input logic gray, input int bad_writes);
        int c;
        cyc_in_frame = 0;
        pix_k        = 0;
        hs_pulses    = 0;
        hs_width     = 0;
        hs_prev_fall = -1;
        vs_low       = 0;
        blank_run    = 0;
        blank_lines  = 0;
        hs_prev      = 1'b1;
        blank_prev   = 1'b0;
        gray_mode    = gray;
        sample_outputs();
        for (c = 1; c < FRAME_CYCLES; c++) begin
            @(posedge clk_25_vga);
            if (c == 1) begin
                sw_grayscale <= gray;   // still inside the vsync pulse
            end
            if (c <= bad_writes) begin
                wr_en   <= 1'b1;
                wr_addr <= BAD_ADDR[c-1];
                wr_data <= cam_display_pkg::rgb565_t'($random(seed));
            end else begin
                wr_en <= 1'b0;
            end
            @(negedge clk_25_vga);
            sample_outputs();
        end
        check_count(hs_pulses, cam_display_pkg::V_TOTAL, "hsync pulses per frame");
        check_count(vs_low, cam_display_pkg::V_SYNC * cam_display_pkg::H_TOTAL, "vsync low");
        check_count(blank_lines, cam_display_pkg::V_ACTIVE, "active lines");
        check_count(pix_k, cam_display_pkg::H_ACTIVE * cam_display_pkg::V_ACTIVE, "active pixels");
    endtask

    task automatic test_reset();
        @(negedge clk_25_vga);
        check_idle_outputs("in reset");
        @(posedge clk_25_vga);
        rst_n <= 1'b1;
        repeat (3) begin
            @(negedge clk_25_vga);
            check_idle_outputs("after reset");   // pipeline still filling
        end
    endtask

    task automatic load_frame();
        int a;
        for (a = 0; a < cam_display_pkg::FB_DEPTH; a++) begin
            ref_frame[a] = cam_display_pkg::rgb565_t'($random(seed));
            @(posedge clk_25_vga);
            wr_en   <= 1'b1;
            wr_addr <= cam_display_pkg::fb_addr_t'(a);
            wr_data <= ref_frame[a];
        end
        @(posedge clk_25_vga);
        wr_en <= 1'b0;
    endtask

    task automatic test_colour_frame();
        wait_vsync_fall(waited);
        run_frame(1'b0, 0);     // also covers sync timing and blanking
    endtask

    task automatic test_grayscale_frame();
        wait_vsync_fall(waited);
        check_count(waited, 1, "frame period");
        run_frame(1'b1, 0);
    endtask

    task automatic test_out_of_range_write();
        wait_vsync_fall(waited);
        check_count(waited, 1, "frame period");
        run_frame(1'b0, 4);
    endtask

    initial begin
        rst_n        = 1'b0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        sw_grayscale = 1'b0;
        seed         = 55;
        test_reset();
        load_frame();
        test_colour_frame();
        test_grayscale_frame();
        test_out_of_range_write();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/cam_display_pkg.sv
rtl/vga_timing.sv
rtl/frame_buffer_bank.sv
rtl/frame_buffer.sv
rtl/pixel_convert.sv
rtl/cam_display_top.sv
verification/tb_cam_display.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_cam_display
FILELIST  := sim.f
BUILD_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
